//--- i3c_defines.svh
`ifndef I3C_DEFINES_SVH
`define I3C_DEFINES_SVH

// Reserved broadcast address, header byte 7E/W
`define I3C_RSVD_ADDR 7'h7E

// Queue depths in records
`define TTI_RX_DEPTH 8
`define CCC_DEPTH 4

// Pin synchronizer length, flops per pin
`define SYNC_STAGES 2

// Hex field width of one vector line
`define HEX_VEC_WIDTH 32

`endif

//--- i3c_pkg.sv
package i3c_pkg;

  // Monitor to flow FSM, one set of strobes per clock
  typedef struct packed {
    logic       det_start;   // START from idle bus
    logic       det_rstart;  // Repeated START
    logic       det_stop;    // STOP
    logic       byte_valid;  // Byte assembled, data held until next one
    logic [7:0] byte_data;   // MSB first on the wire
    logic       det_tbit;    // 9th bit sampled, target not driving
    logic       tbit;        // Value of that 9th bit
  } bus_event_t;

  // Flow FSM to monitor
  typedef struct packed {
    logic ack_en;  // Pull SDA low in the coming 9th bit
    logic clear;   // Drop bit count and release SDA
  } ack_ctrl_t;

  // Bit position inside a frame
  typedef enum logic [1:0] {
    PhaseIdle,     // Bus free or after terminate
    PhaseData,     // Shifting 8 data bits
    PhaseAckWait,  // 8th bit high, waiting for SCL fall
    PhaseAck       // 9th bit, ACK or T-bit
  } bit_phase_e;

endpackage

//--- controller_pkg.sv
package controller_pkg;

  // Static target setup, held steady while the bus is busy
  typedef struct packed {
    logic [6:0] static_addr;
    logic       enable;
    logic       standby_mode;  // Target answers only in standby
  } target_cfg_t;

  // Receive queue entry, one per private write data byte
  typedef struct packed {
    logic [7:0] data;
    logic       first;       // First byte after the address header
    logic       parity_err;  // T-bit was not odd parity of data
  } tti_rx_rec_t;

  // CCC queue entry, one per broadcast or direct CCC
  typedef struct packed {
    logic [7:0] code;
    logic       direct;     // Code 80 and up
    logic       addressed;  // Our address followed the direct CCC
    logic       rnw;        // RnW bit of that address header
    logic [7:0] def_byte;
    logic       has_def;    // def_byte holds a captured byte
  } ccc_rec_t;

endpackage

//--- tti_queue.sv
`timescale 1ns/1ps

module tti_queue #(
  parameter type T_PAYLOAD = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  T_PAYLOAD data_i,
  input  logic     pop_i,
  input  logic     clear_i,     // Clears overflow only
  output T_PAYLOAD data_o,
  output logic     empty_o,
  output logic     overflow_o
);

  localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T_PAYLOAD      mem_q [DEPTH];
  logic [aw-1:0] wr_ptr_q, rd_ptr_q;
  logic [aw:0]   count_q;      // One extra bit to tell full from empty
  logic          full;
  logic          do_push, do_pop;
  logic          overflow_q;

  assign full    = count_q == (aw + 1)'(DEPTH);
  assign empty_o = count_q == '0;
  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & ~full;  // Full queue drops the push

  // Storage, written only on accepted push
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == aw'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == aw'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;

      if (clear_i) overflow_q <= 1'b0;
      else if (push_i && full) overflow_q <= 1'b1;  // Sticky
    end
  end

  assign data_o     = mem_q[rd_ptr_q];  // Head visible without a pop
  assign overflow_o = overflow_q;

endmodule

//--- i3c_bus_monitor.sv
`timescale 1ns/1ps
`include "i3c_defines.svh"

module i3c_bus_monitor
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  input  ack_ctrl_t  ack_ctrl_i,
  output bus_event_t event_o,
  output logic       sda_oe_o
);

  // Sync flops plus one stage to line up with the previous sample
  localparam int pipe_len = `SYNC_STAGES + 2;

  logic [pipe_len-1:0] scl_pipe_q, sda_pipe_q;
  logic                scl_s, scl_q;     // Current and previous SCL
  logic                sda_s, sda_q;     // Current and previous SDA
  logic                scl_rise, scl_fall;
  logic                start_cond, stop_cond;

  bit_phase_e phase_q;
  logic [2:0] bit_cnt_q;   // Wraps to 0 after the 8th bit
  logic [6:0] shift_q;     // First 7 bits of the byte
  logic       busy_q;      // Between START and STOP
  logic       sda_oe_q;
  bus_event_t event_q;

  // Both pins idle high, so the pipes reset to ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_pipe_q <= '1;
      sda_pipe_q <= '1;
    end else begin
      scl_pipe_q <= {scl_pipe_q[pipe_len-2:0], scl_i};
      sda_pipe_q <= {sda_pipe_q[pipe_len-2:0], sda_i};
    end
  end

  assign scl_s = scl_pipe_q[pipe_len-2];  // SYNC_STAGES+1 cycles after the pin
  assign scl_q = scl_pipe_q[pipe_len-1];
  assign sda_s = sda_pipe_q[pipe_len-2];
  assign sda_q = sda_pipe_q[pipe_len-1];

  assign scl_rise = scl_s & ~scl_q;
  assign scl_fall = ~scl_s & scl_q;

  // SDA moving while SCL stays high
  assign start_cond = ~sda_s & sda_q & scl_s & scl_q;
  assign stop_cond  = sda_s & ~sda_q & scl_s & scl_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q   <= PhaseIdle;
      bit_cnt_q <= '0;
      shift_q   <= '0;
      busy_q    <= 1'b0;
      sda_oe_q  <= 1'b0;
      event_q   <= '0;
    end else begin
      // Strobes last one cycle, byte_data and tbit hold
      event_q.det_start  <= 1'b0;
      event_q.det_rstart <= 1'b0;
      event_q.det_stop   <= 1'b0;
      event_q.byte_valid <= 1'b0;
      event_q.det_tbit   <= 1'b0;

      if (ack_ctrl_i.clear) begin
        phase_q   <= PhaseIdle;  // Terminate, wait for next START
        bit_cnt_q <= '0;
        busy_q    <= 1'b0;
        sda_oe_q  <= 1'b0;
      end else if (start_cond) begin
        event_q.det_start  <= ~busy_q;
        event_q.det_rstart <= busy_q;  // Already busy, so Sr
        busy_q    <= 1'b1;
        phase_q   <= PhaseData;
        bit_cnt_q <= '0;
        sda_oe_q  <= 1'b0;
      end else if (stop_cond) begin
        event_q.det_stop <= 1'b1;
        busy_q   <= 1'b0;
        phase_q  <= PhaseIdle;
        sda_oe_q <= 1'b0;
      end else begin
        unique case (phase_q)
          PhaseData: begin
            // Sample on rising SCL, MSB first
            if (scl_rise) begin
              shift_q   <= {shift_q[5:0], sda_s};
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                event_q.byte_valid <= 1'b1;
                event_q.byte_data  <= {shift_q, sda_s};
                phase_q            <= PhaseAckWait;
              end
            end
          end
          PhaseAckWait: begin
            // FSM answer is settled by the time SCL falls
            if (scl_fall) begin
              sda_oe_q <= ack_ctrl_i.ack_en;
              phase_q  <= PhaseAck;
            end
          end
          PhaseAck: begin
            if (scl_rise && !sda_oe_q) begin
              event_q.det_tbit <= 1'b1;  // Controller's T-bit or NACK level
              event_q.tbit     <= sda_s;
            end
            if (scl_fall) begin
              sda_oe_q <= 1'b0;      // Release at end of 9th bit
              phase_q  <= PhaseData;
            end
          end
          default: begin
            // Idle, SCL pulses ignored until START
          end
        endcase
      end
    end
  end

  assign event_o  = event_q;
  assign sda_oe_o = sda_oe_q;

endmodule

//--- flow_standby.sv
`timescale 1ns/1ps
`include "i3c_defines.svh"

module flow_standby
  import controller_pkg::*;
  import i3c_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  target_cfg_t cfg_i,
  input  bus_event_t  event_i,
  output ack_ctrl_t   ack_ctrl_o,
  output logic        rx_push_o,
  output tti_rx_rec_t rx_rec_o,
  output logic        ccc_push_o,
  output ccc_rec_t    ccc_rec_o,
  input  logic        terminate_force_i,
  output logic        terminate_complete_o
);

  typedef enum logic [3:0] {
    Idle,
    AddressHeaderWait,
    AddressHeaderRead,
    SecondByteWait,
    SecondByteRead,
    NextByteWait,
    NextByteRead,
    CCCDetect,
    CCCWait,          // Direct CCC, before Sr
    CCCDirectRead,    // Direct CCC, waiting for target header
    CCCDirectWrite,   // Direct CCC, decode target header
    PrivateWrite,
    GenericError      // NACKed, ignore until STOP or Sr
  } fsm_state_e;

  fsm_state_e  state_q, state_d;
  logic        active;
  logic        hdr_rsvd, hdr_ours;
  logic        bus_end;
  logic        ack_q;
  logic        first_q;
  logic        rx_push_q, ccc_push_q;
  logic        term_done_q;
  tti_rx_rec_t rx_rec_q;
  ccc_rec_t    ccc_q;   // Record under assembly, pushed as is

  assign active   = cfg_i.enable & cfg_i.standby_mode;
  assign hdr_rsvd = event_i.byte_data == {`I3C_RSVD_ADDR, 1'b0};
  assign hdr_ours = event_i.byte_data[7:1] == cfg_i.static_addr;
  assign bus_end  = event_i.det_stop | event_i.det_rstart;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (active && (event_i.det_start || event_i.det_rstart)) state_d = AddressHeaderWait;
      end
      AddressHeaderWait: begin
        if (event_i.byte_valid) state_d = AddressHeaderRead;
        else if (event_i.det_stop) state_d = Idle;
      end
      AddressHeaderRead: begin
        if (hdr_rsvd) state_d = SecondByteWait;
        else if (hdr_ours && !event_i.byte_data[0]) state_d = PrivateWrite;
        else state_d = GenericError;  // Reads and foreign headers
      end
      SecondByteWait: begin
        if (event_i.byte_valid) state_d = SecondByteRead;
        else if (event_i.det_stop) state_d = Idle;
        else if (event_i.det_rstart) state_d = AddressHeaderWait;
      end
      SecondByteRead: state_d = CCCDetect;
      CCCDetect: state_d = ccc_q.direct ? CCCWait : NextByteWait;
      CCCWait: begin
        if (event_i.det_rstart) state_d = CCCDirectRead;
        else if (event_i.det_stop) state_d = Idle;
      end
      CCCDirectRead: begin
        if (event_i.byte_valid) state_d = CCCDirectWrite;
        else if (event_i.det_stop) state_d = Idle;
      end
      CCCDirectWrite: state_d = NextByteWait;
      NextByteWait: begin
        if (event_i.byte_valid) state_d = NextByteRead;
        else if (event_i.det_stop) state_d = Idle;
        else if (event_i.det_rstart) state_d = AddressHeaderWait;
      end
      NextByteRead: state_d = NextByteWait;
      PrivateWrite, GenericError: begin
        if (event_i.det_stop) state_d = Idle;
        else if (event_i.det_rstart) state_d = AddressHeaderWait;
      end
      default: state_d = Idle;
    endcase
    if (terminate_force_i) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      ack_q       <= 1'b0;
      first_q     <= 1'b0;
      rx_push_q   <= 1'b0;
      ccc_push_q  <= 1'b0;
      term_done_q <= 1'b0;
      rx_rec_q    <= '0;
      ccc_q       <= '0;
    end else begin
      state_q     <= state_d;
      rx_push_q   <= 1'b0;
      ccc_push_q  <= 1'b0;
      term_done_q <= terminate_force_i;  // Done one cycle after force

      // ACK request lives from decision to next bit boundary
      if (event_i.byte_valid || event_i.det_tbit || event_i.det_start || bus_end ||
          terminate_force_i) begin
        ack_q <= 1'b0;
      end

      unique case (state_q)
        AddressHeaderRead: begin
          ack_q   <= hdr_rsvd | (hdr_ours & ~event_i.byte_data[0]);
          first_q <= 1'b1;
        end
        SecondByteRead: begin
          ccc_q        <= '0;  // New CCC, fields from previous one dropped
          ccc_q.code   <= event_i.byte_data;
          ccc_q.direct <= event_i.byte_data[7];
        end
        CCCWait: begin
          // Defining byte of a direct CCC comes before Sr
          if (event_i.byte_valid && !ccc_q.has_def) begin
            ccc_q.def_byte <= event_i.byte_data;
            ccc_q.has_def  <= 1'b1;
          end
        end
        CCCDirectWrite: begin
          if (hdr_ours) begin
            ack_q           <= 1'b1;
            ccc_q.addressed <= 1'b1;
            ccc_q.rnw       <= event_i.byte_data[0];
          end
        end
        NextByteRead: begin
          if (!ccc_q.direct && !ccc_q.has_def) begin
            ccc_q.def_byte <= event_i.byte_data;  // Later bytes ignored
            ccc_q.has_def  <= 1'b1;
          end
        end
        PrivateWrite: begin
          // byte_data still holds the byte the T-bit closes
          if (event_i.det_tbit && !terminate_force_i) begin
            rx_push_q           <= 1'b1;
            rx_rec_q.data       <= event_i.byte_data;
            rx_rec_q.first      <= first_q;
            rx_rec_q.parity_err <= event_i.tbit == ^event_i.byte_data;
            first_q             <= 1'b0;
          end
        end
        default: begin
        end
      endcase

      // CCC record closes at STOP or Sr
      if (bus_end && !terminate_force_i &&
          (state_q inside {CCCWait, CCCDirectRead, NextByteWait})) begin
        ccc_push_q <= 1'b1;
      end
    end
  end

  assign ack_ctrl_o.ack_en = ack_q;
  assign ack_ctrl_o.clear  = terminate_force_i;  // Monitor idles on the same edge

  assign rx_push_o            = rx_push_q;
  assign rx_rec_o             = rx_rec_q;
  assign ccc_push_o           = ccc_push_q;
  assign ccc_rec_o            = ccc_q;
  assign terminate_complete_o = term_done_q;

endmodule

//--- i3c_target_standby.sv
`timescale 1ns/1ps
`include "i3c_defines.svh"

module i3c_target_standby
  import controller_pkg::*;
  import i3c_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        sda_oe_o,               // 1 pulls SDA low
  input  target_cfg_t cfg_i,
  output tti_rx_rec_t rx_rec_o,
  output logic        rx_empty_o,
  input  logic        rx_pop_i,
  output ccc_rec_t    ccc_rec_o,
  output logic        ccc_empty_o,
  input  logic        ccc_pop_i,
  output logic        rx_overflow_o,
  input  logic        terminate_force_i,
  output logic        terminate_complete_o
);

  bus_event_t  bus_event;
  ack_ctrl_t   ack_ctrl;
  logic        rx_push, ccc_push;
  tti_rx_rec_t rx_push_rec;
  ccc_rec_t    ccc_push_rec;

  i3c_bus_monitor u_bus_monitor (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .ack_ctrl_i (ack_ctrl),
    .event_o    (bus_event),
    .sda_oe_o   (sda_oe_o)
  );

  flow_standby u_flow_standby (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cfg_i                (cfg_i),
    .event_i              (bus_event),
    .ack_ctrl_o           (ack_ctrl),
    .rx_push_o            (rx_push),
    .rx_rec_o             (rx_push_rec),
    .ccc_push_o           (ccc_push),
    .ccc_rec_o            (ccc_push_rec),
    .terminate_force_i    (terminate_force_i),
    .terminate_complete_o (terminate_complete_o)
  );

  // Private write data, overflow reported
  tti_queue #(.T_PAYLOAD(tti_rx_rec_t), .DEPTH(`TTI_RX_DEPTH)) u_rx_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (rx_push),
    .data_i     (rx_push_rec),
    .pop_i      (rx_pop_i),
    .clear_i    (terminate_force_i),
    .data_o     (rx_rec_o),
    .empty_o    (rx_empty_o),
    .overflow_o (rx_overflow_o)
  );

  // CCC records, drops on full go unreported
  tti_queue #(.T_PAYLOAD(ccc_rec_t), .DEPTH(`CCC_DEPTH)) u_ccc_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (ccc_push),
    .data_i     (ccc_push_rec),
    .pop_i      (ccc_pop_i),
    .clear_i    (terminate_force_i),
    .data_o     (ccc_rec_o),
    .empty_o    (ccc_empty_o),
    .overflow_o ()
  );

endmodule

//--- tb_i3c_target_standby.sv
`timescale 1ns/1ps
`include "i3c_defines.svh"

module tb_i3c_target_standby
  import controller_pkg::*;
();

  localparam int clk_period_ns = 100;
  localparam int scl_half      = 6;  // Clocks per SCL half period
  localparam int scl_period_ns = 2 * scl_half * clk_period_ns;
  // Pin sync, event flop, push flop and FIFO write, with margin
  localparam int rec_wait      = scl_half + `SYNC_STAGES + 6;
  localparam int term_wait     = 8;

  logic        clk_i;
  logic        rst_ni;
  logic        scl_drv, sda_drv;  // Controller side of the bus
  logic        sda_bus;           // Wired-AND with the target
  logic        sda_oe;
  target_cfg_t cfg;
  tti_rx_rec_t rx_rec;
  ccc_rec_t    ccc_rec;
  logic        rx_empty, ccc_empty;
  logic        rx_pop, ccc_pop;
  logic        rx_overflow;
  logic        term_force, term_done;

  logic        hdr_next;   // Next byte is an address header
  logic        ack_seen;   // SDA level in the last 9th bit
  int          err_value, err_other;
  bit          vec_loaded;
  int          timeout_ns;
  logic [63:0]               vec_op [$];
  logic [`HEX_VEC_WIDTH-1:0] vec_val [$];

  assign sda_bus = sda_drv & ~sda_oe;  // Open drain

  i3c_target_standby u_i3c_target_standby (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .scl_i                (scl_drv),
    .sda_i                (sda_bus),
    .sda_oe_o             (sda_oe),
    .cfg_i                (cfg),
    .rx_rec_o             (rx_rec),
    .rx_empty_o           (rx_empty),
    .rx_pop_i             (rx_pop),
    .ccc_rec_o            (ccc_rec),
    .ccc_empty_o          (ccc_empty),
    .ccc_pop_i            (ccc_pop),
    .rx_overflow_o        (rx_overflow),
    .terminate_force_i    (term_force),
    .terminate_complete_o (term_done)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_ns / 2) clk_i = ~clk_i;
  end

  task automatic hold_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // One SCL pulse, SDA set shortly after SCL falls, sampled mid high phase
  task automatic clock_bit(input logic b, output logic seen);
    hold_cycles(1);
    sda_drv <= b;
    hold_cycles(scl_half - 1);
    scl_drv <= 1'b1;
    hold_cycles(scl_half / 2);
    @(negedge clk_i);
    seen = sda_bus;
    hold_cycles(scl_half - scl_half / 2);
    scl_drv <= 1'b0;
  endtask

  task automatic bus_start();
    sda_drv <= 1'b0;  // SDA falls, SCL high
    hold_cycles(scl_half);
    scl_drv <= 1'b0;
    hold_cycles(scl_half);
    hdr_next = 1'b1;
  endtask

  task automatic bus_rstart();
    hold_cycles(1);
    sda_drv <= 1'b1;
    hold_cycles(scl_half - 1);
    scl_drv <= 1'b1;
    hold_cycles(scl_half);
    sda_drv <= 1'b0;  // Sr while SCL high
    hold_cycles(scl_half);
    scl_drv <= 1'b0;
    hold_cycles(scl_half);
    hdr_next = 1'b1;
  endtask

  task automatic bus_stop();
    hold_cycles(1);
    sda_drv <= 1'b0;
    hold_cycles(scl_half - 1);
    scl_drv <= 1'b1;
    hold_cycles(scl_half);
    sda_drv <= 1'b1;  // SDA rises, SCL high
    hold_cycles(scl_half);
    hold_cycles($urandom % 21);  // Idle gap before next transfer
  endtask

  // Bits 7:0 data, bit 8 spoils the T-bit
  task automatic send_byte(input logic [`HEX_VEC_WIDTH-1:0] v);
    logic tbit;
    logic seen;
    int   i;
    tbit = ~^v[7:0] ^ v[8];  // Odd parity over data and T-bit
    for (i = 7; i >= 0; i--) begin
      clock_bit(v[i], seen);
    end
    // Headers leave the 9th bit to the target
    clock_bit(hdr_next ? 1'b1 : tbit, ack_seen);
    hdr_next = 1'b0;
  endtask

  task automatic check_rx(input tti_rx_rec_t exp, input tti_rx_rec_t act);
    if (act !== exp) begin
      err_value++;
      $display("FAIL %0t rx_rec_o expected %h got %h", $time, exp, act);
    end
  endtask

  task automatic check_ccc(input ccc_rec_t exp, input ccc_rec_t act);
    if (act !== exp) begin
      err_value++;
      $display("FAIL %0t ccc_rec_o expected %h got %h", $time, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_value++;
      $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // Ends on a falling edge with ok set when the queue holds a record
  task automatic await_record(input bit from_ccc, output bit ok);
    int n;
    n = 0;
    @(negedge clk_i);
    while ((from_ccc ? ccc_empty : rx_empty) && n < rec_wait) begin
      @(negedge clk_i);
      n++;
    end
    ok = !(from_ccc ? ccc_empty : rx_empty);
    if (!ok) begin
      err_other++;
      $display("%s queue stayed empty while a record was expected",
               from_ccc ? "CCC" : "Receive");
    end
  endtask

  task automatic pop_record(input bit from_ccc);
    if (from_ccc) ccc_pop <= 1'b1;
    else rx_pop <= 1'b1;
    @(posedge clk_i);
    rx_pop  <= 1'b0;
    ccc_pop <= 1'b0;
  endtask

  task automatic terminate_and_wait();
    bit seen;
    int n;
    seen = 1'b0;
    n = 0;
    term_force <= 1'b1;
    @(posedge clk_i);
    term_force <= 1'b0;
    while (!seen && n < term_wait) begin
      @(negedge clk_i);
      seen = term_done;
      n++;
    end
    if (!seen) begin
      err_other++;
      $display("terminate_complete_o never pulsed after a terminate request");
    end
    @(posedge clk_i);
  endtask

  task automatic load_vectors();
    int                        fd;
    int                        got;
    logic [63:0]               tok;
    logic [`HEX_VEC_WIDTH-1:0] val;
    logic [8*120-1:0]          rest;
    fd = $fopen("tb_i3c_vectors.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("Cannot open the vector file tb_i3c_vectors.txt");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "//") begin
          got = $fgets(rest, fd);  // Rest of a comment line
        end else begin
          got = $fscanf(fd, "%h", val);
          if (got != 1) begin
            err_other++;
            $display("Vector %0s has no hex value", tok);
          end else begin
            vec_op.push_back(tok);
            vec_val.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Starts and ends just after a rising edge
  task automatic run_vector(input logic [63:0] op, input logic [`HEX_VEC_WIDTH-1:0] val);
    bit ok;
    case (op)
      "CFG": begin
        cfg <= target_cfg_t'(val[8:0]);
        hold_cycles(1);
      end
      "START":   bus_start();
      "RSTART":  bus_rstart();
      "STOP":    bus_stop();
      "TERM":    terminate_and_wait();
      "BYTE":    send_byte(val);
      "EXPACK":  check_bit("sda ack bit", 1'b0, ack_seen);
      "EXPNACK": check_bit("sda ack bit", 1'b1, ack_seen);
      "EXPRX": begin
        await_record(1'b0, ok);
        if (ok) check_rx(tti_rx_rec_t'(val[9:0]), rx_rec);
        @(posedge clk_i);
        if (ok) pop_record(1'b0);
      end
      "EXPCCC": begin
        await_record(1'b1, ok);
        if (ok) check_ccc(ccc_rec_t'(val[19:0]), ccc_rec);
        @(posedge clk_i);
        if (ok) pop_record(1'b1);
      end
      "EXPEMPTY": begin
        @(negedge clk_i);
        check_bit("rx_empty_o", val[1], rx_empty);
        check_bit("ccc_empty_o", val[0], ccc_empty);
        @(posedge clk_i);
      end
      "EXPOVF": begin
        @(negedge clk_i);
        check_bit("rx_overflow_o", val[0], rx_overflow);
        @(posedge clk_i);
      end
      default: begin
        err_other++;
        $display("Unknown vector opcode %0s", op);
      end
    endcase
  endtask

  initial begin : main_flow
    void'($urandom(32'h03a80d68));
    rst_ni     = 1'b0;
    scl_drv    = 1'b1;  // Bus free
    sda_drv    = 1'b1;
    cfg        = '0;
    rx_pop     = 1'b0;
    ccc_pop    = 1'b0;
    term_force = 1'b0;
    hdr_next   = 1'b0;
    ack_seen   = 1'b1;
    err_value  = 0;
    err_other  = 0;
    load_vectors();
    timeout_ns = (vec_op.size() + 10) * 40 * scl_period_ns;
    vec_loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Idle outputs straight after reset
    check_bit("sda_oe_o", 1'b0, sda_oe);
    check_bit("terminate_complete_o", 1'b0, term_done);
    check_bit("rx_overflow_o", 1'b0, rx_overflow);
    check_bit("rx_empty_o", 1'b1, rx_empty);
    check_bit("ccc_empty_o", 1'b1, ccc_empty);
    @(posedge clk_i);
    foreach (vec_op[i]) begin
      run_vector(vec_op[i], vec_val[i]);
    end
    hold_cycles(4);
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget of 40 SCL periods per vector
  initial begin : watchdog
    wait (vec_loaded);
    #(timeout_ns);
    $display("Run timed out at %0t before all vectors were done", $time);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
i3c_pkg.sv
controller_pkg.sv
tti_queue.sv
i3c_bus_monitor.sv
flow_standby.sv
i3c_target_standby.sv
tb_i3c_target_standby.sv

//--- tb_i3c_vectors.txt
// Columns: opcode, hex value. BYTE bit 8 spoils the T-bit, EXPEMPTY bit 1 rx and bit 0 ccc
// EXPRX {data,first,parity_err}, EXPCCC {code,direct,addressed,rnw,def_byte,has_def}
CFG AB
// Private write, third byte with wrong T-bit
START 0
BYTE 54
EXPACK 0
BYTE 11
BYTE 22
BYTE 133
BYTE 44
STOP 0
EXPRX 46
EXPRX 88
EXPRX CD
EXPRX 110
EXPEMPTY 3
// Foreign write header, then read of our address
START 0
BYTE 66
EXPNACK 0
STOP 0
START 0
BYTE 55
EXPNACK 0
STOP 0
EXPEMPTY 3
// Broadcast CCC with and without defining byte
START 0
BYTE FC
EXPACK 0
BYTE 0A
BYTE 08
STOP 0
START 0
BYTE FC
EXPACK 0
BYTE 07
STOP 0
EXPCCC A011
EXPCCC 7000
EXPEMPTY 3
// Direct CCC, Sr closes the code record, our read header closes at STOP
START 0
BYTE FC
EXPACK 0
BYTE 90
RSTART 0
BYTE 55
EXPACK 0
STOP 0
EXPCCC 90800
EXPCCC 90E00
// Same with a foreign address
START 0
BYTE FC
EXPACK 0
BYTE 90
RSTART 0
BYTE 67
EXPNACK 0
STOP 0
EXPCCC 90800
EXPCCC 90800
EXPEMPTY 3
// Nine bytes into the eight deep queue, then terminate
START 0
BYTE 54
EXPACK 0
BYTE 01
BYTE 02
BYTE 03
BYTE 04
BYTE 05
BYTE 06
BYTE 07
BYTE 08
BYTE 09
STOP 0
EXPOVF 1
EXPRX 6
EXPRX 8
EXPRX C
EXPRX 10
EXPRX 14
EXPRX 18
EXPRX 1C
EXPRX 20
EXPEMPTY 3
TERM 0
EXPOVF 0
// Target disabled
CFG A9
START 0
BYTE 54
EXPNACK 0
STOP 0
EXPEMPTY 3
